// File: design/cbuf_pkg.sv
package cbuf_pkg;

  // ====================
  // buffer geometry
  // ====================

  // four banks, one RAM each
  localparam int bank_num = 4;
  localparam int bank_bits = 2;

  // words held by a single bank RAM
  localparam int ram_depth = 16;
  localparam int ram_depth_bits = 4;

  // upper bank_bits pick the bank, lower ram_depth_bits pick the word
  localparam int addr_bits = bank_bits + ram_depth_bits;

  // one word per write or read beat
  localparam int data_bits = 32;

  // ====================
  // pipeline depths
  // ====================

  // read enable to read valid, counted in clock edges
  localparam int rd_latency = 5;

  // register stages between a write port and the RAM write edge
  localparam int wr_latency = 2;

  // ====================
  // common types
  // ====================

  // full buffer address as seen on the ports
  typedef logic [addr_bits-1:0] cbuf_addr_t;

  // word index inside one bank
  typedef logic [ram_depth_bits-1:0] ram_addr_t;

  // bank number, taken from the top address bits
  typedef logic [bank_bits-1:0] bank_idx_t;

  // buffer word
  typedef logic [data_bits-1:0] cbuf_data_t;

  // one bit per bank, used for one-hot enables
  typedef logic [bank_num-1:0] bank_vec_t;

endpackage

// File: design/cbuf_ram_if.sv
interface cbuf_ram_if;

  // per-bank write strobe, already merged over both write ports
  cbuf_pkg::bank_vec_t wr_en;

  // per-bank word index and data for the write
  cbuf_pkg::ram_addr_t wr_addr [cbuf_pkg::bank_num];
  cbuf_pkg::cbuf_data_t wr_data [cbuf_pkg::bank_num];

  // registered RAM output of each bank, shared by both read clients
  cbuf_pkg::cbuf_data_t rd_data [cbuf_pkg::bank_num];

  // write pipe drives the RAM write fields
  modport wr_side (output wr_en, output wr_addr, output wr_data);

  // bank array takes writes and returns read words
  modport ram_side (input wr_en, input wr_addr, input wr_data, output rd_data);

  // read clients only look at the RAM output
  modport rd_side (input rd_data);

endinterface

// File: design/cbuf_wr_pipe.sv
module cbuf_wr_pipe (
  input  logic                 nvdla_core_clk,
  input  logic                 rst,
  input  logic                 cdma_dat_wr_en,
  input  cbuf_pkg::cbuf_addr_t cdma_dat_wr_addr,
  input  cbuf_pkg::cbuf_data_t cdma_dat_wr_data,
  input  logic                 cdma_wt_wr_en,
  input  cbuf_pkg::cbuf_addr_t cdma_wt_wr_addr,
  input  cbuf_pkg::cbuf_data_t cdma_wt_wr_data,
  cbuf_ram_if.wr_side          ram
);

  cbuf_pkg::bank_idx_t  dat_bank;
  cbuf_pkg::bank_idx_t  wt_bank;
  cbuf_pkg::bank_vec_t  dat_bank_en_d0;
  cbuf_pkg::bank_vec_t  wt_bank_en_d0;
  cbuf_pkg::bank_vec_t  dat_bank_en_d1;
  cbuf_pkg::bank_vec_t  wt_bank_en_d1;
  cbuf_pkg::ram_addr_t  dat_addr_d1;
  cbuf_pkg::ram_addr_t  wt_addr_d1;
  cbuf_pkg::cbuf_data_t dat_data_d1;
  cbuf_pkg::cbuf_data_t wt_data_d1;
  // merged bank strobes, one entry per register stage
  cbuf_pkg::bank_vec_t  wr_en_pipe [cbuf_pkg::wr_latency];

  // ====================
  // stage 0 decode
  // ====================

  // bank select comes from the top address bits
  assign dat_bank = cdma_dat_wr_addr[cbuf_pkg::addr_bits-1 -: cbuf_pkg::bank_bits];
  assign wt_bank = cdma_wt_wr_addr[cbuf_pkg::addr_bits-1 -: cbuf_pkg::bank_bits];

  always_comb begin
    dat_bank_en_d0 = '0;
    wt_bank_en_d0 = '0;
    dat_bank_en_d0[dat_bank] = cdma_dat_wr_en;
    wt_bank_en_d0[wt_bank] = cdma_wt_wr_en;
  end

  // ====================
  // stage 1 registers
  // ====================

  always_ff @(posedge nvdla_core_clk) begin
    if (rst) begin
      dat_bank_en_d1 <= '0;
      wt_bank_en_d1 <= '0;
    end else begin
      dat_bank_en_d1 <= dat_bank_en_d0;
      wt_bank_en_d1 <= wt_bank_en_d0;
    end
  end

  // payload only, the bank part of the address is already in the strobes
  always_ff @(posedge nvdla_core_clk) begin
    dat_addr_d1 <= cdma_dat_wr_addr[cbuf_pkg::ram_depth_bits-1:0];
    wt_addr_d1 <= cdma_wt_wr_addr[cbuf_pkg::ram_depth_bits-1:0];
    dat_data_d1 <= cdma_dat_wr_data;
    wt_data_d1 <= cdma_wt_wr_data;
  end

  // merged strobe travels alongside the per-port ones
  always_ff @(posedge nvdla_core_clk) begin
    if (rst) begin
      for (int s = 0; s < cbuf_pkg::wr_latency; s++) begin
        wr_en_pipe[s] <= '0;
      end
    end else begin
      wr_en_pipe[0] <= dat_bank_en_d0 | wt_bank_en_d0;
      for (int s = 1; s < cbuf_pkg::wr_latency; s++) begin
        wr_en_pipe[s] <= wr_en_pipe[s-1];
      end
    end
  end

  // ====================
  // stage 2 bank mux
  // ====================

  // ports never share a bank in one cycle, so and-or muxing is enough
  always_ff @(posedge nvdla_core_clk) begin
    for (int b = 0; b < cbuf_pkg::bank_num; b++) begin
      ram.wr_addr[b] <= ({cbuf_pkg::ram_depth_bits{dat_bank_en_d1[b]}} & dat_addr_d1) |
                        ({cbuf_pkg::ram_depth_bits{wt_bank_en_d1[b]}} & wt_addr_d1);
      ram.wr_data[b] <= ({cbuf_pkg::data_bits{dat_bank_en_d1[b]}} & dat_data_d1) |
                        ({cbuf_pkg::data_bits{wt_bank_en_d1[b]}} & wt_data_d1);
    end
  end

  // RAM word is written on the edge after this
  assign ram.wr_en = wr_en_pipe[cbuf_pkg::wr_latency-1];

endmodule

// File: design/cbuf_bank_array.sv
module cbuf_bank_array (
  input  logic                nvdla_core_clk,
  input  logic                rst,
  input  cbuf_pkg::bank_vec_t dat_rd_en,
  input  cbuf_pkg::ram_addr_t dat_rd_addr,
  input  cbuf_pkg::bank_vec_t wt_rd_en,
  input  cbuf_pkg::ram_addr_t wt_rd_addr,
  cbuf_ram_if.ram_side        ram
);

  cbuf_pkg::bank_vec_t rd_en_w;
  cbuf_pkg::ram_addr_t rd_addr_w [cbuf_pkg::bank_num];
  cbuf_pkg::bank_vec_t rd_en_d1;
  cbuf_pkg::ram_addr_t rd_addr_d1 [cbuf_pkg::bank_num];

  // ====================
  // read request merge
  // ====================

  // both clients share each bank's single read port
  // a bank is never requested by both in the same cycle
  always_comb begin
    for (int b = 0; b < cbuf_pkg::bank_num; b++) begin
      rd_en_w[b] = dat_rd_en[b] | wt_rd_en[b];
      rd_addr_w[b] = ({cbuf_pkg::ram_depth_bits{dat_rd_en[b]}} & dat_rd_addr) |
                     ({cbuf_pkg::ram_depth_bits{wt_rd_en[b]}} & wt_rd_addr);
    end
  end

  // one flop stage on the read control before the RAM
  always_ff @(posedge nvdla_core_clk) begin
    if (rst) begin
      rd_en_d1 <= '0;
    end else begin
      rd_en_d1 <= rd_en_w;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    for (int b = 0; b < cbuf_pkg::bank_num; b++) begin
      rd_addr_d1[b] <= rd_addr_w[b];
    end
  end

  // ====================
  // bank RAMs
  // ====================

  for (genvar b = 0; b < cbuf_pkg::bank_num; b++) begin : g_bank
    cbuf_pkg::cbuf_data_t mem [cbuf_pkg::ram_depth];
    cbuf_pkg::cbuf_data_t rd_word;

    // read-first, a same-cycle write to the same word returns the old value
    always_ff @(posedge nvdla_core_clk) begin
      if (ram.wr_en[b]) begin
        mem[ram.wr_addr[b]] <= ram.wr_data[b];
      end
      // output register holds its value between reads
      if (rd_en_d1[b]) begin
        rd_word <= mem[rd_addr_d1[b]];
      end
    end

    assign ram.rd_data[b] = rd_word;
  end

endmodule

// File: design/cbuf_rd_port.sv
module cbuf_rd_port (
  input  logic                 nvdla_core_clk,
  input  logic                 rst,
  input  logic                 rd_en,
  input  cbuf_pkg::cbuf_addr_t rd_addr,
  output cbuf_pkg::bank_vec_t  bank_rd_en,
  output cbuf_pkg::ram_addr_t  bank_rd_addr,
  cbuf_ram_if.rd_side          ram,
  output logic                 rd_valid,
  output cbuf_pkg::cbuf_data_t rd_data
);

  cbuf_pkg::bank_idx_t  rd_bank;
  cbuf_pkg::bank_vec_t  bank_en_d1;
  cbuf_pkg::bank_vec_t  bank_en_d2;
  cbuf_pkg::cbuf_data_t l1_data [cbuf_pkg::bank_num];
  cbuf_pkg::cbuf_data_t l2_data_w;
  cbuf_pkg::cbuf_data_t l2_data;
  // valid stages after the bank enable pipe, last bit is rd_valid
  logic [cbuf_pkg::rd_latency-3:0] valid_sr;

  // ====================
  // request decode
  // ====================

  assign rd_bank = rd_addr[cbuf_pkg::addr_bits-1 -: cbuf_pkg::bank_bits];

  // one-hot bank request toward the bank array
  always_comb begin
    bank_rd_en = '0;
    bank_rd_en[rd_bank] = rd_en;
  end

  // word index goes unmasked, the bank array masks it with the enable
  assign bank_rd_addr = rd_addr[cbuf_pkg::ram_depth_bits-1:0];

  // ====================
  // enable delay
  // ====================

  // d2 lines up with the registered RAM word of the same request
  always_ff @(posedge nvdla_core_clk) begin
    if (rst) begin
      bank_en_d1 <= '0;
      bank_en_d2 <= '0;
    end else begin
      bank_en_d1 <= bank_rd_en;
      bank_en_d2 <= bank_en_d1;
    end
  end

  // ====================
  // reduction pipe
  // ====================

  // level 1, keep only the banks this port asked for
  always_ff @(posedge nvdla_core_clk) begin
    for (int b = 0; b < cbuf_pkg::bank_num; b++) begin
      l1_data[b] <= ram.rd_data[b] & {cbuf_pkg::data_bits{bank_en_d2[b]}};
    end
  end

  // level 2, or across all banks
  always_comb begin
    l2_data_w = '0;
    for (int b = 0; b < cbuf_pkg::bank_num; b++) begin
      l2_data_w = l2_data_w | l1_data[b];
    end
  end

  // output register
  always_ff @(posedge nvdla_core_clk) begin
    l2_data <= l2_data_w;
    rd_data <= l2_data;
  end

  // valid follows the data through the last three stages
  always_ff @(posedge nvdla_core_clk) begin
    if (rst) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[cbuf_pkg::rd_latency-4:0], |bank_en_d2};
    end
  end

  assign rd_valid = valid_sr[cbuf_pkg::rd_latency-3];

endmodule

// File: design/cbuf_top.sv
module cbuf_top (
  input  logic                 nvdla_core_clk,
  input  logic                 rst,
  // feature data write port
  input  logic                 cdma_dat_wr_en,
  input  cbuf_pkg::cbuf_addr_t cdma_dat_wr_addr,
  input  cbuf_pkg::cbuf_data_t cdma_dat_wr_data,
  // weight write port
  input  logic                 cdma_wt_wr_en,
  input  cbuf_pkg::cbuf_addr_t cdma_wt_wr_addr,
  input  cbuf_pkg::cbuf_data_t cdma_wt_wr_data,
  // feature data read port
  input  logic                 sc_dat_rd_en,
  input  cbuf_pkg::cbuf_addr_t sc_dat_rd_addr,
  output logic                 sc_dat_rd_valid,
  output cbuf_pkg::cbuf_data_t sc_dat_rd_data,
  // weight read port
  input  logic                 sc_wt_rd_en,
  input  cbuf_pkg::cbuf_addr_t sc_wt_rd_addr,
  output logic                 sc_wt_rd_valid,
  output cbuf_pkg::cbuf_data_t sc_wt_rd_data
);

  // per-bank read requests from each client
  cbuf_pkg::bank_vec_t dat_bank_rd_en;
  cbuf_pkg::ram_addr_t dat_bank_rd_addr;
  cbuf_pkg::bank_vec_t wt_bank_rd_en;
  cbuf_pkg::ram_addr_t wt_bank_rd_addr;

  // write fields and RAM outputs shared by all blocks
  cbuf_ram_if ram_if ();

  // ====================
  // write path
  // ====================

  cbuf_wr_pipe wr_pipe (
    .nvdla_core_clk   (nvdla_core_clk),
    .rst              (rst),
    .cdma_dat_wr_en   (cdma_dat_wr_en),
    .cdma_dat_wr_addr (cdma_dat_wr_addr),
    .cdma_dat_wr_data (cdma_dat_wr_data),
    .cdma_wt_wr_en    (cdma_wt_wr_en),
    .cdma_wt_wr_addr  (cdma_wt_wr_addr),
    .cdma_wt_wr_data  (cdma_wt_wr_data),
    .ram              (ram_if.wr_side)
  );

  // ====================
  // storage
  // ====================

  cbuf_bank_array banks (
    .nvdla_core_clk (nvdla_core_clk),
    .rst            (rst),
    .dat_rd_en      (dat_bank_rd_en),
    .dat_rd_addr    (dat_bank_rd_addr),
    .wt_rd_en       (wt_bank_rd_en),
    .wt_rd_addr     (wt_bank_rd_addr),
    .ram            (ram_if.ram_side)
  );

  // ====================
  // read clients
  // ====================

  cbuf_rd_port rd_dat (
    .nvdla_core_clk (nvdla_core_clk),
    .rst            (rst),
    .rd_en          (sc_dat_rd_en),
    .rd_addr        (sc_dat_rd_addr),
    .bank_rd_en     (dat_bank_rd_en),
    .bank_rd_addr   (dat_bank_rd_addr),
    .ram            (ram_if.rd_side),
    .rd_valid       (sc_dat_rd_valid),
    .rd_data        (sc_dat_rd_data)
  );

  cbuf_rd_port rd_wt (
    .nvdla_core_clk (nvdla_core_clk),
    .rst            (rst),
    .rd_en          (sc_wt_rd_en),
    .rd_addr        (sc_wt_rd_addr),
    .bank_rd_en     (wt_bank_rd_en),
    .bank_rd_addr   (wt_bank_rd_addr),
    .ram            (ram_if.rd_side),
    .rd_valid       (sc_wt_rd_valid),
    .rd_data        (sc_wt_rd_data)
  );

endmodule

// File: verif/cbuf_properties.sv
module cbuf_properties (
  input logic                 nvdla_core_clk,
  input logic                 rst,
  input logic                 cdma_dat_wr_en,
  input cbuf_pkg::cbuf_addr_t cdma_dat_wr_addr,
  input logic                 cdma_wt_wr_en,
  input cbuf_pkg::cbuf_addr_t cdma_wt_wr_addr,
  input logic                 sc_dat_rd_en,
  input cbuf_pkg::cbuf_addr_t sc_dat_rd_addr,
  input logic                 sc_dat_rd_valid,
  input logic                 sc_wt_rd_en,
  input cbuf_pkg::cbuf_addr_t sc_wt_rd_addr,
  input logic                 sc_wt_rd_valid
);

  timeunit 1ns;
  timeprecision 1ps;

  // ====================
  // read timing
  // ====================

  // valid is sampled high rd_latency edges after its enable was sampled
  dat_valid_delay: assert property (@(posedge nvdla_core_clk) disable iff (rst)
    sc_dat_rd_valid == $past(sc_dat_rd_en, cbuf_pkg::rd_latency))
    else $error("data read valid out of step with its enable");

  wt_valid_delay: assert property (@(posedge nvdla_core_clk) disable iff (rst)
    sc_wt_rd_valid == $past(sc_wt_rd_en, cbuf_pkg::rd_latency))
    else $error("weight read valid out of step with its enable");

  // ====================
  // bank conflicts
  // ====================

  rd_bank_clash: assert property (@(posedge nvdla_core_clk) disable iff (rst)
    !(sc_dat_rd_en && sc_wt_rd_en &&
      sc_dat_rd_addr[cbuf_pkg::addr_bits-1 -: cbuf_pkg::bank_bits] ==
      sc_wt_rd_addr[cbuf_pkg::addr_bits-1 -: cbuf_pkg::bank_bits]))
    else $error("both read ports requested one bank in the same cycle");

  wr_bank_clash: assert property (@(posedge nvdla_core_clk) disable iff (rst)
    !(cdma_dat_wr_en && cdma_wt_wr_en &&
      cdma_dat_wr_addr[cbuf_pkg::addr_bits-1 -: cbuf_pkg::bank_bits] ==
      cdma_wt_wr_addr[cbuf_pkg::addr_bits-1 -: cbuf_pkg::bank_bits]))
    else $error("both write ports wrote one bank in the same cycle");

endmodule

bind cbuf_top cbuf_properties props (.*);

// File: verif/cbuf_tb.sv
module cbuf_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] seed = 32'h4a75b588;
  localparam int num_ops = 500;
  localparam int reset_cycles = 10;
  localparam int drain_timeout = 40;
  localparam int words = 2 ** cbuf_pkg::addr_bits;
  // a word is read no sooner than this many cycles after its write
  localparam int wr_rd_gap = 4;

  logic                 nvdla_core_clk;
  logic                 rst;
  logic                 cdma_dat_wr_en;
  cbuf_pkg::cbuf_addr_t cdma_dat_wr_addr;
  cbuf_pkg::cbuf_data_t cdma_dat_wr_data;
  logic                 cdma_wt_wr_en;
  cbuf_pkg::cbuf_addr_t cdma_wt_wr_addr;
  cbuf_pkg::cbuf_data_t cdma_wt_wr_data;
  logic                 sc_dat_rd_en;
  cbuf_pkg::cbuf_addr_t sc_dat_rd_addr;
  logic                 sc_dat_rd_valid;
  cbuf_pkg::cbuf_data_t sc_dat_rd_data;
  logic                 sc_wt_rd_en;
  cbuf_pkg::cbuf_addr_t sc_wt_rd_addr;
  logic                 sc_wt_rd_valid;
  cbuf_pkg::cbuf_data_t sc_wt_rd_data;

  // shadow of the buffer and the drive slot of each word's last write
  cbuf_pkg::cbuf_data_t shadow [words];
  int                   last_wr [words];
  // expected word and due cycle of every read in flight, per read port
  cbuf_pkg::cbuf_data_t dat_exp_q [$];
  int                   dat_due_q [$];
  cbuf_pkg::cbuf_data_t wt_exp_q [$];
  int                   wt_due_q [$];
  logic [31:0]          rng_state;
  int                   cyc;
  int                   drive_cnt;

  cbuf_top dut0 (.*);

  // ====================
  // clock and helpers
  // ====================

  always #20 nvdla_core_clk = ~nvdla_core_clk;

  // edge counter, times the valid pulses
  always @(posedge nvdla_core_clk) begin
    cyc <= cyc + 1;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // expected read word, straight from the shadow memory
  function automatic cbuf_pkg::cbuf_data_t ref_read(input cbuf_pkg::cbuf_addr_t addr);
    return shadow[addr];
  endfunction

  function automatic cbuf_pkg::bank_idx_t bank_of(input cbuf_pkg::cbuf_addr_t addr);
    return addr[cbuf_pkg::addr_bits-1 -: cbuf_pkg::bank_bits];
  endfunction

  task automatic stop_with_failure();
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_data(input string port, input cbuf_pkg::cbuf_data_t got,
                            input cbuf_pkg::cbuf_data_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s read data %h, expected %h", $time, port, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_valid(input string port, input logic valid, input int pending,
                             input int due);
    if (valid && pending == 0) begin
      $display("ERROR at %0t: %s read valid with no read outstanding", $time, port);
      stop_with_failure();
    end else if (valid && due != cyc) begin
      $display("MISMATCH at %0t: %s read valid in cycle %0d, expected %0d", $time, port,
               cyc, due);
      stop_with_failure();
    end else if (!valid && pending != 0 && due <= cyc) begin
      $display("ERROR at %0t: %s read valid missing, due in cycle %0d", $time, port, due);
      stop_with_failure();
    end
  endtask

  // ====================
  // compare process
  // ====================

  // outputs are settled half a cycle after the edge
  always @(negedge nvdla_core_clk) begin
    if (rst === 1'b0) begin
      check_valid("data", sc_dat_rd_valid, dat_exp_q.size(),
                  dat_due_q.size() != 0 ? dat_due_q[0] : 0);
      if (sc_dat_rd_valid) begin
        check_data("data", sc_dat_rd_data, dat_exp_q.pop_front());
        void'(dat_due_q.pop_front());
      end
      check_valid("weight", sc_wt_rd_valid, wt_exp_q.size(),
                  wt_due_q.size() != 0 ? wt_due_q[0] : 0);
      if (sc_wt_rd_valid) begin
        check_data("weight", sc_wt_rd_data, wt_exp_q.pop_front());
        void'(wt_due_q.pop_front());
      end
    end
  end

  // ====================
  // stimulus
  // ====================

  // one clock of traffic on all four ports
  task automatic drive_cycle(
    input logic                 d_we,
    input cbuf_pkg::cbuf_addr_t d_waddr,
    input cbuf_pkg::cbuf_data_t d_wdata,
    input logic                 w_we,
    input cbuf_pkg::cbuf_addr_t w_waddr,
    input cbuf_pkg::cbuf_data_t w_wdata,
    input logic                 d_re,
    input cbuf_pkg::cbuf_addr_t d_raddr,
    input logic                 w_re,
    input cbuf_pkg::cbuf_addr_t w_raddr
  );
    @(posedge nvdla_core_clk);
    cdma_dat_wr_en <= d_we;
    cdma_dat_wr_addr <= d_waddr;
    cdma_dat_wr_data <= d_wdata;
    cdma_wt_wr_en <= w_we;
    cdma_wt_wr_addr <= w_waddr;
    cdma_wt_wr_data <= w_wdata;
    sc_dat_rd_en <= d_re;
    sc_dat_rd_addr <= d_raddr;
    sc_wt_rd_en <= w_re;
    sc_wt_rd_addr <= w_raddr;
    // cyc still lags this edge by one, valid is seen rd_latency negedges later
    if (d_re) begin
      dat_exp_q.push_back(ref_read(d_raddr));
      dat_due_q.push_back(cyc + 1 + cbuf_pkg::rd_latency);
    end
    if (w_re) begin
      wt_exp_q.push_back(ref_read(w_raddr));
      wt_due_q.push_back(cyc + 1 + cbuf_pkg::rd_latency);
    end
    // reads above come first, the RAM is read-first
    if (d_we) begin
      shadow[d_waddr] = d_wdata;
      last_wr[d_waddr] = drive_cnt;
    end
    if (w_we) begin
      shadow[w_waddr] = w_wdata;
      last_wr[w_waddr] = drive_cnt;
    end
    drive_cnt++;
  endtask

  task automatic idle(input int n);
    for (int i = 0; i < n; i++) begin
      drive_cycle(1'b0, '0, '0, 1'b0, '0, '0, 1'b0, '0, 1'b0, '0);
    end
  endtask

  // write every word through one port, random data
  task automatic fill_all(input bit via_wt);
    cbuf_pkg::cbuf_data_t d;
    for (int a = 0; a < words; a++) begin
      d = next_rand();
      drive_cycle(!via_wt, cbuf_pkg::cbuf_addr_t'(a), d,
                  via_wt, cbuf_pkg::cbuf_addr_t'(a), d, 1'b0, '0, 1'b0, '0);
    end
  endtask

  // back to back reads of every word through one port
  task automatic read_all(input bit via_wt);
    for (int a = 0; a < words; a++) begin
      drive_cycle(1'b0, '0, '0, 1'b0, '0, '0,
                  !via_wt, cbuf_pkg::cbuf_addr_t'(a), via_wt, cbuf_pkg::cbuf_addr_t'(a));
    end
  endtask

  task automatic drain_reads(output bit drained);
    int waited;
    waited = 0;
    while ((dat_exp_q.size() != 0 || wt_exp_q.size() != 0) && waited < drain_timeout) begin
      idle(1);
      waited++;
    end
    drained = dat_exp_q.size() == 0 && wt_exp_q.size() == 0;
  endtask

  task automatic settle();
    bit drained;
    drain_reads(drained);
    if (!drained) begin
      $display("ERROR at %0t: timeout waiting for read valid", $time);
      stop_with_failure();
    end
  endtask

  task automatic run_random_traffic();
    logic [31:0]          r;
    cbuf_pkg::cbuf_addr_t d_wa;
    cbuf_pkg::cbuf_addr_t w_wa;
    cbuf_pkg::cbuf_addr_t d_ra;
    cbuf_pkg::cbuf_addr_t w_ra;
    logic                 d_we;
    logic                 w_we;
    logic                 d_re;
    logic                 w_re;
    for (int i = 0; i < num_ops; i++) begin
      r = next_rand();
      d_wa = r[5:0];
      w_wa = r[11:6];
      d_ra = r[17:12];
      w_ra = r[23:18];
      // write ports stay on separate banks, so do read ports
      d_we = r[24];
      w_we = r[25] && !(d_we && bank_of(w_wa) == bank_of(d_wa));
      d_re = r[26] && (drive_cnt - last_wr[d_ra] >= wr_rd_gap);
      w_re = r[27] && (drive_cnt - last_wr[w_ra] >= wr_rd_gap) &&
             !(d_re && bank_of(w_ra) == bank_of(d_ra));
      drive_cycle(d_we, d_wa, next_rand(), w_we, w_wa, next_rand(), d_re, d_ra, w_re, w_ra);
    end
  endtask

  // ====================
  // test sequence
  // ====================

  initial begin
    bit                   drained;
    logic [31:0]          r;
    cbuf_pkg::cbuf_addr_t a;
    cbuf_pkg::cbuf_addr_t b;
    nvdla_core_clk = 1'b0;
    rst = 1'b1;
    cdma_dat_wr_en = 1'b0;
    cdma_dat_wr_addr = '0;
    cdma_dat_wr_data = '0;
    cdma_wt_wr_en = 1'b0;
    cdma_wt_wr_addr = '0;
    cdma_wt_wr_data = '0;
    sc_dat_rd_en = 1'b0;
    sc_dat_rd_addr = '0;
    sc_wt_rd_en = 1'b0;
    sc_wt_rd_addr = '0;
    rng_state = seed;
    cyc = 0;
    drive_cnt = 0;
    for (int i = 0; i < words; i++) begin
      last_wr[i] = -wr_rd_gap;
    end
    repeat (reset_cycles) @(posedge nvdla_core_clk);
    rst <= 1'b0;

    // quiet ports, no valid may show up
    idle(20);
    // data port in, data port out, one read per cycle
    fill_all(1'b0);
    idle(wr_rd_gap);
    read_all(1'b0);
    settle();
    // storage shared across the two clients
    fill_all(1'b1);
    idle(wr_rd_gap);
    read_all(1'b0);
    settle();
    fill_all(1'b0);
    idle(wr_rd_gap);
    read_all(1'b1);
    settle();
    // both read ports in the same cycle, top bank bit flipped
    for (int i = 0; i < 16; i++) begin
      r = next_rand();
      a = r[5:0];
      b = a;
      b[cbuf_pkg::addr_bits-1] = ~a[cbuf_pkg::addr_bits-1];
      drive_cycle(1'b0, '0, '0, 1'b0, '0, '0, 1'b1, a, 1'b1, b);
    end
    settle();
    run_random_traffic();

    drain_reads(drained);
    if (drained) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("ERROR at %0t: timeout waiting for read valid", $time);
      stop_with_failure();
    end
  end

endmodule

// File: list.f
design/cbuf_pkg.sv
design/cbuf_ram_if.sv
design/cbuf_wr_pipe.sv
design/cbuf_bank_array.sv
design/cbuf_rd_port.sv
design/cbuf_top.sv
verif/cbuf_properties.sv
verif/cbuf_tb.sv

// File: run.sh
#!/bin/sh
# build the convolution buffer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 --top-module cbuf_tb -f list.f -o cbuf_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/cbuf_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench prints its fail message on any error
if grep -q "sim failed" "$log"; then
  exit 1
fi
exit 0
